/* include/mem_map.svh */
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

// memory-mapped device addresses.

// load returns the free-running cycle counter.
`define HW_COUNTER_ADDR 32'hffff_ff00

// store pushes the low byte into the uart transmit fifo.
`define UART_TX_ADDR 32'hffff_ff04

`endif

/* rtl/mem_pkg.sv */
package mem_pkg;

  // data and address width.
  localparam int XLEN = 32;

  // destination register index width.
  localparam int REG_BITS = 5;

  // access width of a load or store.
  typedef enum logic [1:0] {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd2
  } mem_width_e;

  // request kind coming from execute.
  typedef enum logic [1:0] {
    MEM_OP_NONE  = 2'd0, // pass-through.
    MEM_OP_LOAD  = 2'd1,
    MEM_OP_STORE = 2'd2
  } mem_op_e;

endpackage

/* rtl/store_align.sv */
`timescale 1ns/1ns
`include "mem_map.svh"

module store_align #(
  parameter int MEM_WORDS = 1024
) (
  input  logic [mem_pkg::XLEN-1:0]      addr,
  input  mem_pkg::mem_width_e           width,
  input  logic [mem_pkg::XLEN-1:0]      wdata,
  input  logic                          store,
  output logic [$clog2(MEM_WORDS)-1:0]  line,
  output logic [1:0]                    offset,
  output logic [3:0]                    byte_we,
  output logic [mem_pkg::XLEN-1:0]      shifted_wdata,
  output logic                          uart_push,
  output logic [7:0]                    uart_push_data
);

  localparam int LINE_W = $clog2(MEM_WORDS);

  logic [3:0] lane_mask;
  logic       uart_hit;
  logic       mapped_hit;

  // addresses past the ram wrap around.
  assign line   = addr[LINE_W+1:2];
  assign offset = addr[1:0];

  assign uart_hit   = (addr == `UART_TX_ADDR);
  assign mapped_hit = uart_hit || (addr == `HW_COUNTER_ADDR);

  always_comb begin
    case (width)
      mem_pkg::MEM_BYTE: begin
        lane_mask = 4'b0001 << offset;
      end
      mem_pkg::MEM_HALF: begin
        lane_mask = 4'b0011 << offset; // aligned, so offset is 0 or 2.
      end
      default: begin
        lane_mask = 4'b1111;
      end
    endcase
  end

  // low bytes move up into their lanes, the rest is masked off.
  assign shifted_wdata = wdata << {offset, 3'b000};

  // device stores never reach the ram.
  assign byte_we = (store && !mapped_hit) ? lane_mask : 4'b0000;

  assign uart_push      = store && uart_hit;
  assign uart_push_data = wdata[7:0];

endmodule

/* rtl/data_bram.sv */
`timescale 1ns/1ns

module data_bram #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                          clk,
  input  logic                          re,
  input  logic [3:0]                    byte_we,
  input  logic [$clog2(MEM_WORDS)-1:0]  addr,
  input  logic [mem_pkg::XLEN-1:0]      wdata,
  output logic [mem_pkg::XLEN-1:0]      rdata
);

  logic [mem_pkg::XLEN-1:0] mem [MEM_WORDS];

  // byte lane writes.
  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (byte_we[i]) begin
        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
      end
    end
  end

  // registered read, holds while re is low.
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[addr];
    end
  end

endmodule

/* rtl/uart_buffer.sv */
`timescale 1ns/1ns

module uart_buffer #(
  parameter int UART_DEPTH = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       push,
  input  logic [7:0] push_data,
  output logic       full,
  output logic [7:0] uart_data,
  output logic       uart_valid,
  input  logic       uart_ready
);

  localparam int PTR_W = (UART_DEPTH > 1) ? $clog2(UART_DEPTH) : 1;
  localparam int CNT_W = $clog2(UART_DEPTH + 1);

  logic [7:0]       fifo_mem [UART_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full       = (count == CNT_W'(UART_DEPTH));
  assign uart_valid = (count != '0);
  assign uart_data  = fifo_mem[rd_ptr];

  assign do_push = push && !full; // dropped when full.
  assign do_pop  = uart_valid && uart_ready;

  always_ff @(posedge clk) begin
    if (do_push) begin
      fifo_mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(UART_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(UART_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/memory_access.sv */
`timescale 1ns/1ns
`include "mem_map.svh"

module memory_access #(
  parameter int MEM_WORDS = 1024
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  mem_pkg::mem_op_e              in_op,
  input  mem_pkg::mem_width_e           in_width,
  input  logic                          in_unsigned,
  input  logic [mem_pkg::XLEN-1:0]      in_addr,
  input  logic [mem_pkg::XLEN-1:0]      in_wdata,
  input  logic [mem_pkg::XLEN-1:0]      in_pc,
  input  logic [mem_pkg::REG_BITS-1:0]  in_rd,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [mem_pkg::XLEN-1:0]      out_pc,
  output logic [mem_pkg::REG_BITS-1:0]  out_rd,
  output logic                          out_is_load,
  output logic [mem_pkg::XLEN-1:0]      out_alu_result,
  output logic [mem_pkg::XLEN-1:0]      out_data,
  input  logic                          uart_full,
  output logic                          uart_push,
  output logic [7:0]                    uart_push_data
);

  logic                          accept;
  logic                          is_load;
  logic                          is_store;
  logic                          uart_store;
  logic                          hc_hit;
  logic [$clog2(MEM_WORDS)-1:0]  line;
  logic [1:0]                    offset;
  logic [3:0]                    byte_we;
  logic [mem_pkg::XLEN-1:0]      shifted_wdata;
  logic [mem_pkg::XLEN-1:0]      ram_rdata;
  logic [mem_pkg::XLEN-1:0]      hw_count;

  // load in flight.
  mem_pkg::mem_width_e           wb_width;
  logic                          wb_unsigned;
  logic [1:0]                    wb_offset;
  logic                          wb_hc;
  logic [mem_pkg::XLEN-1:0]      wb_count;

  assign is_load    = (in_op == mem_pkg::MEM_OP_LOAD);
  assign is_store   = (in_op == mem_pkg::MEM_OP_STORE);
  assign uart_store = is_store && (in_addr == `UART_TX_ADDR);
  assign hc_hit     = is_load && (in_addr == `HW_COUNTER_ADDR);

  // stall when the result can't move or the uart fifo has no room.
  assign in_ready = (!out_valid || out_ready) && (!uart_full || !uart_store);
  assign accept   = in_valid && in_ready;

  store_align #(
    .MEM_WORDS(MEM_WORDS)
  ) align0 (
    .addr          (in_addr),
    .width         (in_width),
    .wdata         (in_wdata),
    .store         (accept && is_store),
    .line          (line),
    .offset        (offset),
    .byte_we       (byte_we),
    .shifted_wdata (shifted_wdata),
    .uart_push     (uart_push),
    .uart_push_data(uart_push_data)
  );

  data_bram #(
    .MEM_WORDS(MEM_WORDS)
  ) bram0 (
    .clk    (clk),
    .re     (accept && is_load && !hc_hit),
    .byte_we(byte_we),
    .addr   (line),
    .wdata  (shifted_wdata),
    .rdata  (ram_rdata)
  );

  // free-running cycle counter.
  always_ff @(posedge clk) begin
    if (rst) begin
      hw_count <= '0;
    end else begin
      hw_count <= hw_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_pc         <= in_pc;
      out_rd         <= in_rd;
      out_is_load    <= is_load;
      out_alu_result <= in_addr;
      wb_width       <= in_width;
      wb_unsigned    <= in_unsigned;
      wb_offset      <= offset;
      wb_hc          <= hc_hit;
      wb_count       <= hw_count; // value at the accept edge.
    end
  end

  function automatic logic [mem_pkg::XLEN-1:0] load_extend(
    input logic [mem_pkg::XLEN-1:0] word,
    input mem_pkg::mem_width_e      width,
    input logic                     is_unsigned,
    input logic [1:0]               lane
  );
    logic [mem_pkg::XLEN-1:0] sh;
    logic                     sign;
    sh = word >> {lane, 3'b000};
    case (width)
      mem_pkg::MEM_BYTE: begin
        sign        = !is_unsigned && sh[7];
        load_extend = {{(mem_pkg::XLEN-8){sign}}, sh[7:0]};
      end
      mem_pkg::MEM_HALF: begin
        sign        = !is_unsigned && sh[15];
        load_extend = {{(mem_pkg::XLEN-16){sign}}, sh[15:0]};
      end
      default: begin
        sign        = 1'b0;
        load_extend = word;
      end
    endcase
  endfunction

  always_comb begin
    if (!out_is_load) begin
      out_data = '0; // stores and pass-throughs.
    end else if (wb_hc) begin
      out_data = wb_count;
    end else begin
      out_data = load_extend(ram_rdata, wb_width, wb_unsigned, wb_offset);
    end
  end

endmodule

/* rtl/mem_stage_top.sv */
`timescale 1ns/1ns

module mem_stage_top #(
  parameter int MEM_WORDS  = 1024,
  parameter int UART_DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  mem_pkg::mem_op_e              in_op,
  input  mem_pkg::mem_width_e           in_width,
  input  logic                          in_unsigned,
  input  logic [mem_pkg::XLEN-1:0]      in_addr,
  input  logic [mem_pkg::XLEN-1:0]      in_wdata,
  input  logic [mem_pkg::XLEN-1:0]      in_pc,
  input  logic [mem_pkg::REG_BITS-1:0]  in_rd,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic [mem_pkg::XLEN-1:0]      out_pc,
  output logic [mem_pkg::REG_BITS-1:0]  out_rd,
  output logic                          out_is_load,
  output logic [mem_pkg::XLEN-1:0]      out_alu_result,
  output logic [mem_pkg::XLEN-1:0]      out_data,
  output logic [7:0]                    uart_data,
  output logic                          uart_valid,
  input  logic                          uart_ready
);

  logic       uart_push;
  logic [7:0] uart_push_data;
  logic       uart_full;

  memory_access #(
    .MEM_WORDS(MEM_WORDS)
  ) mem0 (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_ready      (in_ready),
    .in_op         (in_op),
    .in_width      (in_width),
    .in_unsigned   (in_unsigned),
    .in_addr       (in_addr),
    .in_wdata      (in_wdata),
    .in_pc         (in_pc),
    .in_rd         (in_rd),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_pc        (out_pc),
    .out_rd        (out_rd),
    .out_is_load   (out_is_load),
    .out_alu_result(out_alu_result),
    .out_data      (out_data),
    .uart_full     (uart_full),
    .uart_push     (uart_push),
    .uart_push_data(uart_push_data)
  );

  uart_buffer #(
    .UART_DEPTH(UART_DEPTH)
  ) uart0 (
    .clk       (clk),
    .rst       (rst),
    .push      (uart_push),
    .push_data (uart_push_data),
    .full      (uart_full),
    .uart_data (uart_data),
    .uart_valid(uart_valid),
    .uart_ready(uart_ready)
  );

endmodule

/* verif/mem_stage_chk.sv */
`timescale 1ns/1ns

module mem_stage_chk (
  input logic                          clk,
  input logic                          rst,
  input logic                          out_valid,
  input logic                          out_ready,
  input logic [mem_pkg::XLEN-1:0]      out_pc,
  input logic [mem_pkg::REG_BITS-1:0]  out_rd,
  input logic                          out_is_load,
  input logic [mem_pkg::XLEN-1:0]      out_alu_result,
  input logic [mem_pkg::XLEN-1:0]      out_data,
  input logic                          uart_valid,
  input logic                          uart_ready,
  input logic [7:0]                    uart_data
);

  // stalled result keeps its place and value.
  out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid &&
      $stable({out_pc, out_rd, out_is_load, out_alu_result, out_data}))
    else $error("write-back result dropped or changed while out_ready was low");

  uart_hold: assert property (@(posedge clk) disable iff (rst)
    uart_valid && !uart_ready |=> uart_valid && $stable(uart_data))
    else $error("uart byte dropped or changed while uart_ready was low");

  // first cycle out of reset.
  reset_idle: assert property (@(posedge clk) $fell(rst) |-> !out_valid && !uart_valid)
    else $error("valid raised right after reset");

endmodule

/* verif/mem_checker.sv */
`timescale 1ns/1ns
`include "mem_map.svh"

module mem_checker #(
  parameter int MEM_WORDS  = 1024,
  parameter int UART_DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          in_valid,
  input  logic                          in_ready,
  input  mem_pkg::mem_op_e              in_op,
  input  mem_pkg::mem_width_e           in_width,
  input  logic                          in_unsigned,
  input  logic [mem_pkg::XLEN-1:0]      in_addr,
  input  logic [mem_pkg::XLEN-1:0]      in_wdata,
  input  logic [mem_pkg::XLEN-1:0]      in_pc,
  input  logic [mem_pkg::REG_BITS-1:0]  in_rd,
  input  logic                          out_valid,
  input  logic                          out_ready,
  input  logic [mem_pkg::XLEN-1:0]      out_pc,
  input  logic [mem_pkg::REG_BITS-1:0]  out_rd,
  input  logic                          out_is_load,
  input  logic [mem_pkg::XLEN-1:0]      out_alu_result,
  input  logic [mem_pkg::XLEN-1:0]      out_data,
  input  logic [7:0]                    uart_data,
  input  logic                          uart_valid,
  input  logic                          uart_ready,
  output int                            errors,
  output int                            results,
  output logic                          idle
);

  localparam int LINE_W = $clog2(MEM_WORDS);

  typedef struct packed {
    logic [mem_pkg::XLEN-1:0]     pc;
    logic [mem_pkg::REG_BITS-1:0] rd;
    logic                         is_load;
    logic [mem_pkg::XLEN-1:0]     alu;
    logic [mem_pkg::XLEN-1:0]     data;
  } result_t;

  logic [7:0]  ref_mem [MEM_WORDS*4]; // byte addressed, index is {line, lane}.
  logic [31:0] cycle_count = '0;
  result_t     exp_q [$];
  logic [7:0]  uart_q [$];
  int          err_cnt = 0;
  int          res_cnt = 0;

  assign errors  = err_cnt;
  assign results = res_cnt;

  function automatic logic [31:0] ref_load(input logic [31:0] addr,
                                           input mem_pkg::mem_width_e width,
                                           input logic is_unsigned);
    logic [LINE_W-1:0] line;
    logic [7:0]        lo;
    logic [7:0]        hi;
    line = addr[LINE_W+1:2];
    lo   = ref_mem[{line, addr[1:0]}];
    hi   = ref_mem[{line, addr[1], 1'b1}];
    if (width == mem_pkg::MEM_BYTE) begin
      ref_load = is_unsigned ? {24'd0, lo} : {{24{lo[7]}}, lo};
    end else if (width == mem_pkg::MEM_HALF) begin
      ref_load = is_unsigned ? {16'd0, hi, lo} : {{16{hi[7]}}, hi, lo};
    end else begin
      ref_load = {ref_mem[{line, 2'd3}], ref_mem[{line, 2'd2}], hi, lo};
    end
  endfunction

  task automatic store_ref(input logic [31:0] addr, input mem_pkg::mem_width_e width,
                           input logic [31:0] data);
    logic [LINE_W-1:0] line;
    int                n;
    line = addr[LINE_W+1:2];
    n    = (width == mem_pkg::MEM_BYTE) ? 1 : (width == mem_pkg::MEM_HALF) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      ref_mem[{line, addr[1:0] + 2'(i)}] = data[i*8 +: 8];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      $display("ERROR %0t: %s is %h, expected %h", $time, name, got, want);
      err_cnt++;
    end
  endtask

  always @(posedge clk) begin
    result_t    want;
    logic [7:0] want_byte;
    logic       want_ready;
    if (rst) begin
      cycle_count <= '0;
    end else begin
      // queues hold what sits in the write-back register and the uart fifo.
      if (in_valid) begin
        want_ready = (exp_q.size() == 0 || out_ready) &&
                     !(uart_q.size() == UART_DEPTH && in_op == mem_pkg::MEM_OP_STORE &&
                       in_addr == `UART_TX_ADDR);
        check_value("in_ready", 32'(in_ready), 32'(want_ready));
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("at %0t the DUT gave a result that no request asked for", $time);
          err_cnt++;
        end else begin
          want = exp_q.pop_front();
          check_value("out_pc", out_pc, want.pc);
          check_value("out_rd", 32'(out_rd), 32'(want.rd));
          check_value("out_is_load", 32'(out_is_load), 32'(want.is_load));
          check_value("out_alu_result", out_alu_result, want.alu);
          check_value("out_data", out_data, want.data);
          res_cnt++;
        end
      end
      if (uart_valid && uart_ready) begin
        if (uart_q.size() == 0) begin
          $display("at %0t the DUT sent a uart byte that was never stored", $time);
          err_cnt++;
        end else begin
          want_byte = uart_q.pop_front();
          check_value("uart_data", 32'(uart_data), 32'(want_byte));
        end
      end
      if (in_valid && in_ready) begin
        want.pc      = in_pc;
        want.rd      = in_rd;
        want.is_load = (in_op == mem_pkg::MEM_OP_LOAD);
        want.alu     = in_addr;
        want.data    = '0;
        if (want.is_load && in_addr == `HW_COUNTER_ADDR) begin
          want.data = cycle_count; // edges since reset, before this one.
        end else if (want.is_load) begin
          want.data = ref_load(in_addr, in_width, in_unsigned);
        end else if (in_op == mem_pkg::MEM_OP_STORE && in_addr == `UART_TX_ADDR) begin
          uart_q.push_back(in_wdata[7:0]);
        end else if (in_op == mem_pkg::MEM_OP_STORE && in_addr != `HW_COUNTER_ADDR) begin
          store_ref(in_addr, in_width, in_wdata);
        end
        exp_q.push_back(want);
      end
      cycle_count <= cycle_count + 32'd1;
    end
    idle = (exp_q.size() == 0) && (uart_q.size() == 0);
  end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/1ns
`include "mem_map.svh"

module tb_top;

  localparam int MEM_WORDS    = 1024;
  localparam int UART_DEPTH   = 8;
  localparam int NUM_REQ      = 2000;
  localparam int INIT_WORDS   = 64; // random traffic stays in this window.
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT_NS   = (NUM_REQ * 20 + RESET_CYCLES) * CLK_PERIOD;
  localparam logic [31:0] ADDR_SPAN = 32'(MEM_WORDS * 4 - 1);

  logic                        clk = 1'b0;
  logic                        rst = 1'b1;
  logic                        in_valid = 1'b0;
  logic                        in_ready;
  mem_pkg::mem_op_e            in_op = mem_pkg::MEM_OP_NONE;
  mem_pkg::mem_width_e         in_width = mem_pkg::MEM_WORD;
  logic                        in_unsigned = 1'b0;
  logic [mem_pkg::XLEN-1:0]    in_addr = '0;
  logic [mem_pkg::XLEN-1:0]    in_wdata = '0;
  logic [mem_pkg::XLEN-1:0]    in_pc = '0;
  logic [mem_pkg::REG_BITS-1:0] in_rd = '0;
  logic                        out_valid;
  logic                        out_ready = 1'b0;
  logic [mem_pkg::XLEN-1:0]    out_pc;
  logic [mem_pkg::REG_BITS-1:0] out_rd;
  logic                        out_is_load;
  logic [mem_pkg::XLEN-1:0]    out_alu_result;
  logic [mem_pkg::XLEN-1:0]    out_data;
  logic [7:0]                  uart_data;
  logic                        uart_valid;
  logic                        uart_ready = 1'b0;
  int                          errors;
  int                          results;
  logic                        idle;
  integer                      seed = 32'hcb50ee6f;
  int                          issued = 0;
  int                          tb_cycle = 0;

  mem_stage_top #(.MEM_WORDS(MEM_WORDS), .UART_DEPTH(UART_DEPTH)) dut0 (.*);

  mem_checker #(.MEM_WORDS(MEM_WORDS), .UART_DEPTH(UART_DEPTH)) chk0 (.*);

  bind mem_stage_top mem_stage_chk hs_chk0 (
    .clk           (clk),
    .rst           (rst),
    .out_valid     (out_valid),
    .out_ready     (out_ready),
    .out_pc        (out_pc),
    .out_rd        (out_rd),
    .out_is_load   (out_is_load),
    .out_alu_result(out_alu_result),
    .out_data      (out_data),
    .uart_valid    (uart_valid),
    .uart_ready    (uart_ready),
    .uart_data     (uart_data)
  );

  always #(CLK_PERIOD/2) clk = ~clk;

  task automatic drive_request(input int idx);
    logic [31:0]         r;
    logic [31:0]         high;
    logic [7:0]          low;
    int                  kind;
    mem_pkg::mem_width_e width;
    r     = $random(seed);
    high  = $random(seed);
    kind  = int'(r[6:0]);
    width = (r[9:8] == 2'd0) ? mem_pkg::MEM_BYTE :
            (r[9:8] == 2'd1) ? mem_pkg::MEM_HALF : mem_pkg::MEM_WORD;
    case (width)
      mem_pkg::MEM_BYTE: low = {r[15:10], r[17:16]};
      mem_pkg::MEM_HALF: low = {r[15:10], r[17], 1'b0};
      default:           low = {r[15:10], 2'b00};
    endcase
    high = (r[19:18] == 2'd0) ? (high & ~ADDR_SPAN) : 32'd0; // upper bits wrap.
    in_valid    <= 1'b1;
    in_pc       <= 32'h1000 + 32'(idx * 4);
    in_rd       <= r[24:20];
    in_unsigned <= r[25];
    in_wdata    <= $random(seed);
    in_width    <= width;
    in_addr     <= high | {24'd0, low};
    if (idx < INIT_WORDS) begin
      // fill the window first so loads never see unwritten ram.
      in_op    <= mem_pkg::MEM_OP_STORE;
      in_width <= mem_pkg::MEM_WORD;
      in_addr  <= 32'(idx * 4);
    end else if (kind < 48) begin
      in_op <= mem_pkg::MEM_OP_LOAD;
    end else if (kind < 90) begin
      in_op <= mem_pkg::MEM_OP_STORE;
    end else if (kind < 104) begin
      in_op   <= mem_pkg::MEM_OP_NONE;
      in_addr <= $random(seed);
    end else if (kind < 116) begin
      in_op    <= mem_pkg::MEM_OP_LOAD;
      in_width <= mem_pkg::MEM_WORD;
      in_addr  <= `HW_COUNTER_ADDR;
    end else begin
      in_op    <= mem_pkg::MEM_OP_STORE;
      in_width <= mem_pkg::MEM_BYTE;
      in_addr  <= `UART_TX_ADDR;
    end
  endtask

  always @(posedge clk) begin
    logic [31:0] r;
    r = $random(seed);
    tb_cycle <= tb_cycle + 1;
    if (!rst) begin
      out_ready  <= (r[1:0] != 2'b00);
      // long uart stall, fills the fifo and backs up uart stores.
      uart_ready <= (r[3:2] != 2'b00) && !(tb_cycle >= 1500 && tb_cycle < 1800);
      if (!in_valid || in_ready) begin
        if (issued < NUM_REQ && r[6:4] != 3'b000) begin
          drive_request(issued);
          issued <= issued + 1;
        end else begin
          in_valid <= 1'b0;
        end
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    while (!(results == NUM_REQ && idle)) begin
      @(posedge clk);
    end
    repeat (4) @(posedge clk);
    $display("run finished: %0d results checked, %0d errors", results, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: only %0d of %0d results came back in time", results, NUM_REQ);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* project.f */
+incdir+include
rtl/mem_pkg.sv
rtl/store_align.sv
rtl/data_bram.sv
rtl/uart_buffer.sv
rtl/memory_access.sv
rtl/mem_stage_top.sv
verif/mem_stage_chk.sv
verif/mem_checker.sv
verif/tb_top.sv

/* Makefile */
# Verilator build and run for the memory-access stage.

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/mem_map.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails on a nonzero exit, on the fail message, or when no pass message appears.
run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '*** TEST FAILED ***' $(LOG) || \
	   ! grep -qF '*** TEST PASSED ***' $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
